// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := rv_core_tb
FILELIST  := all.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+common
common/rv_core_pkg.sv
hw/rv_ifu.sv
hw/rv_regfile.sv
hw/rv_idu.sv
hw/rv_control.sv
hw/rv_exu.sv
hw/rv_lsu.sv
hw/rv_core.sv
tests/rv_core_checker.sv
tests/rv_core_tb.sv

// ==== common/rv_core_defs.svh ====
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Datapath and register file geometry
`define RV_XLEN 32
`define RV_REG_ADDR_WIDTH 5

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== common/rv_core_pkg.sv ====
package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_COPY_B
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic [2:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JAL,
        PC_JALR,
        PC_HOLD
    } pc_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [2:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD,
        MEM_BYTE_U,
        MEM_HALF_U
    } mem_size_e;

endpackage

// ==== hw/rv_control.sv ====
`timescale 1ns/1ps

module rv_control (
    input  logic [31:0]              inst_i,
    input  logic                     br_eq_i,
    input  logic                     br_lt_i,
    input  logic                     br_ltu_i,
    input  logic                     halted_i,
    output rv_core_pkg::alu_op_e     alu_op_o,
    output rv_core_pkg::op1_sel_e    op1_sel_o,
    output rv_core_pkg::op2_sel_e    op2_sel_o,
    output rv_core_pkg::imm_sel_e    imm_sel_o,
    output rv_core_pkg::wb_sel_e     wb_sel_o,
    output rv_core_pkg::mem_size_e   mem_size_o,
    output rv_core_pkg::pc_sel_e     pc_sel_o,
    output logic                     rf_we_o,
    output logic                     mem_en_o,
    output logic                     mem_we_o,
    output logic                     is_ebreak_o
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic                  funct7_b5;
    logic                  br_taken;
    logic                  rf_we;
    logic                  mem_en;
    logic                  mem_we;
    rv_core_pkg::pc_sel_e  pc_sel;
    rv_core_pkg::alu_op_e  arith_op;

    assign opcode    = inst_i[6:0];
    assign funct3    = inst_i[14:12];
    assign funct7_b5 = inst_i[30];

    assign is_ebreak_o = (inst_i == 32'h0010_0073);

    // funct7 bit only selects SUB for register ops, SRA for both
    always_comb begin
        case (funct3)
            3'b001:  arith_op = rv_core_pkg::ALU_SLL;
            3'b010:  arith_op = rv_core_pkg::ALU_SLT;
            3'b011:  arith_op = rv_core_pkg::ALU_SLTU;
            3'b100:  arith_op = rv_core_pkg::ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  arith_op = rv_core_pkg::ALU_OR;
            3'b111:  arith_op = rv_core_pkg::ALU_AND;
            default: arith_op = (funct7_b5 && opcode[5]) ? rv_core_pkg::ALU_SUB
                                                         : rv_core_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  br_taken = br_eq_i;
            3'b001:  br_taken = !br_eq_i;
            3'b100:  br_taken = br_lt_i;
            3'b101:  br_taken = !br_lt_i;
            3'b110:  br_taken = br_ltu_i;
            3'b111:  br_taken = !br_ltu_i;
            default: br_taken = 1'b0;
        endcase
    end

    // Access width from funct3
    always_comb begin
        case (funct3)
            3'b000:  mem_size_o = rv_core_pkg::MEM_BYTE;
            3'b001:  mem_size_o = rv_core_pkg::MEM_HALF;
            3'b100:  mem_size_o = rv_core_pkg::MEM_BYTE_U;
            3'b101:  mem_size_o = rv_core_pkg::MEM_HALF_U;
            default: mem_size_o = rv_core_pkg::MEM_WORD;
        endcase
    end

    always_comb begin
        alu_op_o   = rv_core_pkg::ALU_ADD;
        op1_sel_o  = rv_core_pkg::OP1_RS1;
        op2_sel_o  = rv_core_pkg::OP2_IMM;
        imm_sel_o  = rv_core_pkg::IMM_I;
        wb_sel_o   = rv_core_pkg::WB_ALU;
        pc_sel     = rv_core_pkg::PC_PLUS4;
        rf_we      = 1'b0;
        mem_en     = 1'b0;
        mem_we     = 1'b0;
        case (opcode)
            7'b0110011: begin
                alu_op_o  = arith_op;
                op2_sel_o = rv_core_pkg::OP2_RS2;
                rf_we     = 1'b1;
            end
            7'b0010011: begin
                alu_op_o = arith_op;
                rf_we    = 1'b1;
            end
            7'b0110111: begin
                alu_op_o  = rv_core_pkg::ALU_COPY_B;
                op1_sel_o = rv_core_pkg::OP1_ZERO;
                imm_sel_o = rv_core_pkg::IMM_U;
                rf_we     = 1'b1;
            end
            7'b0010111: begin
                op1_sel_o = rv_core_pkg::OP1_PC;
                imm_sel_o = rv_core_pkg::IMM_U;
                rf_we     = 1'b1;
            end
            7'b1101111: begin
                op1_sel_o = rv_core_pkg::OP1_PC;
                imm_sel_o = rv_core_pkg::IMM_J;
                wb_sel_o  = rv_core_pkg::WB_PC4;
                pc_sel    = rv_core_pkg::PC_JAL;
                rf_we     = 1'b1;
            end
            7'b1100111: begin
                wb_sel_o = rv_core_pkg::WB_PC4;
                pc_sel   = rv_core_pkg::PC_JALR;
                rf_we    = 1'b1;
            end
            7'b1100011: begin
                op2_sel_o = rv_core_pkg::OP2_RS2;
                imm_sel_o = rv_core_pkg::IMM_B;
                pc_sel    = br_taken ? rv_core_pkg::PC_BRANCH : rv_core_pkg::PC_PLUS4;
            end
            7'b0000011: begin
                wb_sel_o = rv_core_pkg::WB_MEM;
                rf_we    = 1'b1;
                mem_en   = 1'b1;
            end
            7'b0100011: begin
                imm_sel_o = rv_core_pkg::IMM_S;
                mem_en    = 1'b1;
                mem_we    = 1'b1;
            end
            default: ;
        endcase
    end

    // EBREAK and the halted state freeze the core
    assign pc_sel_o = (halted_i || is_ebreak_o) ? rv_core_pkg::PC_HOLD : pc_sel;
    assign rf_we_o  = rf_we  && !(halted_i || is_ebreak_o);
    assign mem_en_o = mem_en && !(halted_i || is_ebreak_o);
    assign mem_we_o = mem_we && !(halted_i || is_ebreak_o);

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    output logic [`RV_XLEN-1:0]            imem_addr_o,
    input  logic [31:0]                    imem_rdata_i,
    output logic                           dmem_en_o,
    output logic                           dmem_we_o,
    output logic [`RV_XLEN-1:0]            dmem_addr_o,
    output logic [`RV_XLEN-1:0]            dmem_wdata_o,
    output logic [3:0]                     dmem_wmask_o,
    input  logic [`RV_XLEN-1:0]            dmem_rdata_i,
    output logic                           retire_we_o,
    output logic [`RV_REG_ADDR_WIDTH-1:0]  retire_rd_o,
    output logic [`RV_XLEN-1:0]            retire_data_o,
    output logic                           halt_o
);

    logic [`RV_XLEN-1:0]            pc;
    logic [`RV_XLEN-1:0]            pc_plus4;
    logic [`RV_XLEN-1:0]            br_target;
    logic [`RV_XLEN-1:0]            jal_target;
    logic [`RV_XLEN-1:0]            jalr_target;
    logic [`RV_XLEN-1:0]            op1;
    logic [`RV_XLEN-1:0]            op2;
    logic [`RV_XLEN-1:0]            rs1_data;
    logic [`RV_XLEN-1:0]            rs2_data;
    logic [`RV_XLEN-1:0]            store_data;
    logic [`RV_XLEN-1:0]            alu_result;
    logic [`RV_XLEN-1:0]            rd_data;
    logic [`RV_XLEN-1:0]            load_data;
    logic [`RV_REG_ADDR_WIDTH-1:0]  rs1_addr;
    logic [`RV_REG_ADDR_WIDTH-1:0]  rs2_addr;
    logic [`RV_REG_ADDR_WIDTH-1:0]  rd_addr;
    logic                           br_eq;
    logic                           br_lt;
    logic                           br_ltu;
    logic                           rf_we;
    logic                           is_ebreak;
    logic                           halt_q;
    rv_core_pkg::pc_sel_e           pc_sel;
    rv_core_pkg::alu_op_e           alu_op;
    rv_core_pkg::op1_sel_e          op1_sel;
    rv_core_pkg::op2_sel_e          op2_sel;
    rv_core_pkg::imm_sel_e          imm_sel;
    rv_core_pkg::wb_sel_e           wb_sel;
    rv_core_pkg::mem_size_e         mem_size;

    rv_ifu u_ifu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pc_sel_i     (pc_sel),
        .br_target_i  (br_target),
        .jal_target_i (jal_target),
        .jalr_target_i(jalr_target),
        .pc_o         (pc),
        .pc_plus4_o   (pc_plus4)
    );

    rv_regfile #(
        .DATA_WIDTH(`RV_XLEN),
        .ADDR_WIDTH(`RV_REG_ADDR_WIDTH)
    ) u_regfile (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (rf_we),
        .waddr_i (rd_addr),
        .wdata_i (rd_data),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    rv_idu u_idu (
        .inst_i       (imem_rdata_i),
        .pc_i         (pc),
        .op1_sel_i    (op1_sel),
        .op2_sel_i    (op2_sel),
        .imm_sel_i    (imm_sel),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rd_addr_o    (rd_addr),
        .op1_o        (op1),
        .op2_o        (op2),
        .store_data_o (store_data),
        .br_eq_o      (br_eq),
        .br_lt_o      (br_lt),
        .br_ltu_o     (br_ltu),
        .br_target_o  (br_target),
        .jal_target_o (jal_target),
        .jalr_target_o(jalr_target)
    );

    rv_control u_control (
        .inst_i     (imem_rdata_i),
        .br_eq_i    (br_eq),
        .br_lt_i    (br_lt),
        .br_ltu_i   (br_ltu),
        .halted_i   (halt_q),
        .alu_op_o   (alu_op),
        .op1_sel_o  (op1_sel),
        .op2_sel_o  (op2_sel),
        .imm_sel_o  (imm_sel),
        .wb_sel_o   (wb_sel),
        .mem_size_o (mem_size),
        .pc_sel_o   (pc_sel),
        .rf_we_o    (rf_we),
        .mem_en_o   (dmem_en_o),
        .mem_we_o   (dmem_we_o),
        .is_ebreak_o(is_ebreak)
    );

    rv_exu u_exu (
        .op1_i       (op1),
        .op2_i       (op2),
        .alu_op_i    (alu_op),
        .wb_sel_i    (wb_sel),
        .pc_plus4_i  (pc_plus4),
        .load_data_i (load_data),
        .alu_result_o(alu_result),
        .rd_data_o   (rd_data)
    );

    rv_lsu u_lsu (
        .mem_size_i  (mem_size),
        .addr_lo_i   (alu_result[1:0]),
        .store_data_i(store_data),
        .rdata_i     (dmem_rdata_i),
        .wdata_o     (dmem_wdata_o),
        .wmask_o     (dmem_wmask_o),
        .load_data_o (load_data)
    );

    // Sticky halt, set by the EBREAK edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            halt_q <= 1'b0;
        end else if (is_ebreak) begin
            halt_q <= 1'b1;
        end
    end

    assign halt_o        = is_ebreak || halt_q;
    assign imem_addr_o   = pc;
    assign dmem_addr_o   = alu_result;
    assign retire_we_o   = rf_we && (rd_addr != '0);
    assign retire_rd_o   = rd_addr;
    assign retire_data_o = rd_data;

endmodule

// ==== hw/rv_exu.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_exu (
    input  logic [`RV_XLEN-1:0]   op1_i,
    input  logic [`RV_XLEN-1:0]   op2_i,
    input  rv_core_pkg::alu_op_e  alu_op_i,
    input  rv_core_pkg::wb_sel_e  wb_sel_i,
    input  logic [`RV_XLEN-1:0]   pc_plus4_i,
    input  logic [`RV_XLEN-1:0]   load_data_i,
    output logic [`RV_XLEN-1:0]   alu_result_o,
    output logic [`RV_XLEN-1:0]   rd_data_o
);

    logic [4:0] shamt;

    assign shamt = op2_i[4:0];

    always_comb begin
        case (alu_op_i)
            rv_core_pkg::ALU_SUB:    alu_result_o = op1_i - op2_i;
            rv_core_pkg::ALU_SLL:    alu_result_o = op1_i << shamt;
            rv_core_pkg::ALU_SLT:
                alu_result_o = {{(`RV_XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            rv_core_pkg::ALU_SLTU:
                alu_result_o = {{(`RV_XLEN-1){1'b0}}, op1_i < op2_i};
            rv_core_pkg::ALU_XOR:    alu_result_o = op1_i ^ op2_i;
            rv_core_pkg::ALU_SRL:    alu_result_o = op1_i >> shamt;
            rv_core_pkg::ALU_SRA:    alu_result_o = $unsigned($signed(op1_i) >>> shamt);
            rv_core_pkg::ALU_OR:     alu_result_o = op1_i | op2_i;
            rv_core_pkg::ALU_AND:    alu_result_o = op1_i & op2_i;
            rv_core_pkg::ALU_COPY_B: alu_result_o = op2_i;
            default:                 alu_result_o = op1_i + op2_i;
        endcase
    end

    // Write-back source
    always_comb begin
        case (wb_sel_i)
            rv_core_pkg::WB_MEM: rd_data_o = load_data_i;
            rv_core_pkg::WB_PC4: rd_data_o = pc_plus4_i;
            default:             rd_data_o = alu_result_o;
        endcase
    end

endmodule

// ==== hw/rv_idu.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_idu (
    input  logic [31:0]                    inst_i,
    input  logic [`RV_XLEN-1:0]            pc_i,
    input  rv_core_pkg::op1_sel_e          op1_sel_i,
    input  rv_core_pkg::op2_sel_e          op2_sel_i,
    input  rv_core_pkg::imm_sel_e          imm_sel_i,
    input  logic [`RV_XLEN-1:0]            rs1_data_i,
    input  logic [`RV_XLEN-1:0]            rs2_data_i,
    output logic [`RV_REG_ADDR_WIDTH-1:0]  rs1_addr_o,
    output logic [`RV_REG_ADDR_WIDTH-1:0]  rs2_addr_o,
    output logic [`RV_REG_ADDR_WIDTH-1:0]  rd_addr_o,
    output logic [`RV_XLEN-1:0]            op1_o,
    output logic [`RV_XLEN-1:0]            op2_o,
    output logic [`RV_XLEN-1:0]            store_data_o,
    output logic                           br_eq_o,
    output logic                           br_lt_o,
    output logic                           br_ltu_o,
    output logic [`RV_XLEN-1:0]            br_target_o,
    output logic [`RV_XLEN-1:0]            jal_target_o,
    output logic [`RV_XLEN-1:0]            jalr_target_o
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm;

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        case (imm_sel_i)
            rv_core_pkg::IMM_S: imm = imm_s;
            rv_core_pkg::IMM_B: imm = imm_b;
            rv_core_pkg::IMM_U: imm = imm_u;
            rv_core_pkg::IMM_J: imm = imm_j;
            default:            imm = imm_i;
        endcase
    end

    always_comb begin
        case (op1_sel_i)
            rv_core_pkg::OP1_PC:   op1_o = pc_i;
            rv_core_pkg::OP1_ZERO: op1_o = '0;
            default:               op1_o = rs1_data_i;
        endcase
    end

    assign op2_o        = (op2_sel_i == rv_core_pkg::OP2_IMM) ? imm : rs2_data_i;
    assign store_data_o = rs2_data_i;

    assign br_eq_o  = (rs1_data_i == rs2_data_i);
    assign br_lt_o  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu_o = (rs1_data_i < rs2_data_i);

    assign br_target_o   = pc_i + imm_b;
    assign jal_target_o  = pc_i + imm_j;
    // JALR clears the low bit of the sum
    assign jalr_target_o = (rs1_data_i + imm_i) & ~`RV_XLEN'd1;

endmodule

// ==== hw/rv_ifu.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_ifu (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  rv_core_pkg::pc_sel_e   pc_sel_i,
    input  logic [`RV_XLEN-1:0]    br_target_i,
    input  logic [`RV_XLEN-1:0]    jal_target_i,
    input  logic [`RV_XLEN-1:0]    jalr_target_i,
    output logic [`RV_XLEN-1:0]    pc_o,
    output logic [`RV_XLEN-1:0]    pc_plus4_o
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_next;

    assign pc_plus4_o = pc_q + `RV_XLEN'd4;
    assign pc_o       = pc_q;

    always_comb begin
        case (pc_sel_i)
            rv_core_pkg::PC_BRANCH: pc_next = br_target_i;
            rv_core_pkg::PC_JAL:    pc_next = jal_target_i;
            rv_core_pkg::PC_JALR:   pc_next = jalr_target_i;
            rv_core_pkg::PC_HOLD:   pc_next = pc_q;
            default:                pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `RV_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

// ==== hw/rv_lsu.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_lsu (
    input  rv_core_pkg::mem_size_e  mem_size_i,
    input  logic [1:0]              addr_lo_i,
    input  logic [`RV_XLEN-1:0]     store_data_i,
    input  logic [`RV_XLEN-1:0]     rdata_i,
    output logic [`RV_XLEN-1:0]     wdata_o,
    output logic [3:0]              wmask_o,
    output logic [`RV_XLEN-1:0]     load_data_o
);

    logic [`RV_XLEN-1:0] shifted;

    // Byte and half stores are copied into every lane, the mask picks one
    always_comb begin
        case (mem_size_i)
            rv_core_pkg::MEM_BYTE: begin
                wdata_o = {4{store_data_i[7:0]}};
                wmask_o = 4'b0001 << addr_lo_i;
            end
            rv_core_pkg::MEM_HALF: begin
                wdata_o = {2{store_data_i[15:0]}};
                wmask_o = 4'b0011 << {addr_lo_i[1], 1'b0};
            end
            default: begin
                wdata_o = store_data_i;
                wmask_o = 4'b1111;
            end
        endcase
    end

    assign shifted = rdata_i >> {addr_lo_i, 3'b000};

    always_comb begin
        case (mem_size_i)
            rv_core_pkg::MEM_BYTE:   load_data_o = {{24{shifted[7]}}, shifted[7:0]};
            rv_core_pkg::MEM_HALF:   load_data_o = {{16{shifted[15]}}, shifted[15:0]};
            rv_core_pkg::MEM_BYTE_U: load_data_o = {24'b0, shifted[7:0]};
            rv_core_pkg::MEM_HALF_U: load_data_o = {16'b0, shifted[15:0]};
            default:                 load_data_o = rdata_i;
        endcase
    end

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 5
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] waddr_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic [ADDR_WIDTH-1:0] raddr1_i,
    input  logic [ADDR_WIDTH-1:0] raddr2_i,
    output logic [DATA_WIDTH-1:0] rdata1_o,
    output logic [DATA_WIDTH-1:0] rdata2_o
);

    logic [DATA_WIDTH-1:0] regs [2**ADDR_WIDTH];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads as zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== tests/rv_core_checker.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_checker (
    input logic                          clk_i,
    input logic                          rst_n_i,
    input logic [`RV_XLEN-1:0]           imem_addr_i,
    input logic                          dmem_en_i,
    input logic                          dmem_we_i,
    input logic                          retire_we_i,
    input logic [`RV_REG_ADDR_WIDTH-1:0] retire_rd_i,
    input logic                          halt_i
);

    store_has_enable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dmem_we_i |-> dmem_en_i)
        else $error("data memory write without enable");

    no_x0_retire: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_we_i |-> (retire_rd_i != '0))
        else $error("retire port reported a write to x0");

    halt_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        halt_i |=> halt_i)
        else $error("halt dropped before reset");

    // Nothing commits once halted
    halt_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        halt_i |-> (!retire_we_i && !dmem_we_i))
        else $error("register or memory write while halted");

    fetch_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        imem_addr_i[1:0] == 2'b00)
        else $error("instruction address not word aligned");

endmodule

bind rv_core rv_core_checker u_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .imem_addr_i(imem_addr_o),
    .dmem_en_i  (dmem_en_o),
    .dmem_we_i  (dmem_we_o),
    .retire_we_i(retire_we_o),
    .retire_rd_i(retire_rd_o),
    .halt_i     (halt_o)
);

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_tb;

    localparam int    CLK_PERIOD   = 40;
    localparam int    DRIVE_DELAY  = 2;
    localparam int    SAMPLE_LEAD  = 1;
    localparam int    RESET_CYCLES = 5;
    localparam int    MAX_CYCLES   = 2000;
    localparam int    DRAIN_CYCLES = 4;
    localparam int    MEM_WORDS    = 256;
    localparam string TRACE_FILE   = "tests/rv_core_trace.mem";

    logic                          clk;
    logic                          rst_n;
    logic [`RV_XLEN-1:0]           imem_addr;
    logic [31:0]                   imem_rdata;
    logic                          dmem_en;
    logic                          dmem_we;
    logic [`RV_XLEN-1:0]           dmem_addr;
    logic [`RV_XLEN-1:0]           dmem_wdata;
    logic [3:0]                    dmem_wmask;
    logic [`RV_XLEN-1:0]           dmem_rdata;
    logic                          retire_we;
    logic [`RV_REG_ADDR_WIDTH-1:0] retire_rd;
    logic [`RV_XLEN-1:0]           retire_data;
    logic                          halt;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_rd_data [$];
    logic [31:0] exp_mem_addr [$];
    logic [31:0] exp_mem_data [$];

    int   value_errors = 0;
    int   other_errors = 0;
    int   retire_idx   = 0;
    int   cycles       = 0;
    logic halt_seen    = 1'b0;

    rv_core DUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_en_o    (dmem_en),
        .dmem_we_o    (dmem_we),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_wmask_o (dmem_wmask),
        .dmem_rdata_i (dmem_rdata),
        .retire_we_o  (retire_we),
        .retire_rd_o  (retire_rd),
        .retire_data_o(retire_data),
        .halt_o       (halt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // 256-word memories, combinational read
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin : dmem_write
        logic [31:0] merged;
        if (rst_n && dmem_en && dmem_we) begin
            merged = dmem[dmem_addr[9:2]];
            for (int b = 0; b < 4; b++) begin
                if (dmem_wmask[b]) begin
                    merged[8*b +: 8] = dmem_wdata[8*b +: 8];
                end
            end
            dmem[dmem_addr[9:2]] <= merged;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] field_a;
        logic [31:0] field_b;
        fd = $fopen(TRACE_FILE, "r");
        assert (fd != 0) else begin
            $display("ERROR: could not open trace file %s", TRACE_FILE);
            other_errors++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", kind, field_a, field_b);
                    if (n == 3) begin
                        case (kind)
                            "P": imem[field_a[9:2]] = field_b;
                            "R": begin
                                exp_rd.push_back(field_a);
                                exp_rd_data.push_back(field_b);
                            end
                            "M": begin
                                exp_mem_addr.push_back(field_a);
                                exp_mem_data.push_back(field_b);
                            end
                            default: begin
                                $display("ERROR: unknown record kind in trace line: %s", line);
                                other_errors++;
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
        assert (exp_rd.size() > 0 && exp_mem_addr.size() > 0) else begin
            $display("ERROR: trace holds no retire or memory records");
            other_errors++;
        end
    endtask

    // Retire port compared in program order
    task automatic score_retire();
        if (retire_we) begin
            assert (retire_idx < exp_rd.size()) else begin
                $display("ERROR: unexpected write to x%0d at %0t, trace lists only %0d writes",
                         retire_rd, $time, exp_rd.size());
                other_errors++;
            end
            if (retire_idx < exp_rd.size()) begin
                compare_value("retire_rd_o", exp_rd[retire_idx], 32'(retire_rd));
                compare_value("retire_data_o", exp_rd_data[retire_idx], retire_data);
            end
            retire_idx++;
        end
    endtask

    task automatic verify_memory();
        logic [31:0] word;
        for (int i = 0; i < exp_mem_addr.size(); i++) begin
            word = dmem[exp_mem_addr[i][9:2]];
            compare_value($sformatf("dmem[%h]", exp_mem_addr[i]), exp_mem_data[i], word);
        end
    endtask

    // Sample just before each rising edge
    always begin
        @(posedge clk);
        #(CLK_PERIOD - SAMPLE_LEAD);
        if (rst_n) begin
            score_retire();
            if (halt) begin
                halt_seen = 1'b1;
            end
        end
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        load_trace();

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;

        while (!halt_seen && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        assert (halt_seen) else begin
            $display("ERROR: timeout, halt_o did not rise within %0d cycles", MAX_CYCLES);
            other_errors++;
        end

        // A few idle cycles show that nothing retires after the halt
        repeat (DRAIN_CYCLES) @(posedge clk);
        assert (retire_idx == exp_rd.size()) else begin
            $display("ERROR: core retired %0d register writes but the trace expects %0d",
                     retire_idx, exp_rd.size());
            other_errors++;
        end
        verify_memory();

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== tests/rv_core_trace.mem ====
# P <byte address> <instruction word>   R <rd> <value written>   M <byte address> <final word>
# All fields hex; text after the third field is a note
P 00 123450B7 lui   x1, 0x12345
P 04 67808093 addi  x1, x1, 0x678
P 08 00001117 auipc x2, 0x1
P 0C FF800193 addi  x3, x0, -8
P 10 4011D213 srai  x4, x3, 1
P 14 01C1D293 srli  x5, x3, 28
P 18 00429313 slli  x6, x5, 4
P 1C 0051A3B3 slt   x7, x3, x5
P 20 0051B433 sltu  x8, x3, x5
P 24 403284B3 sub   x9, x5, x3
P 28 0060C533 xor   x10, x1, x6
P 2C 0062E5B3 or    x11, x5, x6
P 30 0F00F613 andi  x12, x1, 0xF0
P 34 00500013 addi  x0, x0, 5
P 38 005006B3 add   x13, x0, x5
P 3C 04102023 sw    x1, 0x40(x0)
P 40 043000A3 sb    x3, 0x41(x0)
P 44 04901123 sh    x9, 0x42(x0)
P 48 04100703 lb    x14, 0x41(x0)
P 4C 04104783 lbu   x15, 0x41(x0)
P 50 04001803 lh    x16, 0x40(x0)
P 54 04205883 lhu   x17, 0x42(x0)
P 58 04002903 lw    x18, 0x40(x0)
P 5C 04301223 sh    x3, 0x44(x0)
P 60 04A005A3 sb    x10, 0x4B(x0)
P 64 00518463 beq   x3, x5, +8 not taken
P 68 00D28463 beq   x5, x13, +8 taken
P 6C 00100F93 addi  x31, x0, 1 skipped
P 70 00D29463 bne   x5, x13, +8 not taken
P 74 00519463 bne   x3, x5, +8 taken
P 78 00100F93 addi  x31, x0, 1 skipped
P 7C 0032C463 blt   x5, x3, +8 not taken
P 80 0051C463 blt   x3, x5, +8 taken
P 84 00100F93 addi  x31, x0, 1 skipped
P 88 0051D463 bge   x3, x5, +8 not taken
P 8C 0032D463 bge   x5, x3, +8 taken
P 90 00100F93 addi  x31, x0, 1 skipped
P 94 0051E463 bltu  x3, x5, +8 not taken
P 98 0032E463 bltu  x5, x3, +8 taken
P 9C 00100F93 addi  x31, x0, 1 skipped
P A0 0032F463 bgeu  x5, x3, +8 not taken
P A4 0051F463 bgeu  x3, x5, +8 taken
P A8 00100F93 addi  x31, x0, 1 skipped
P AC 00800AEF jal   x21, +8
P B0 00100F93 addi  x31, x0, 1 skipped
P B4 0BC00B93 addi  x23, x0, 0xBC
P B8 005B8B67 jalr  x22, 5(x23) to 0xC0
P BC 00100F93 addi  x31, x0, 1 skipped
P C0 015B0C33 add   x24, x22, x21
P C4 00100073 ebreak
P C8 04102023 sw    x1, 0x40(x0) after halt
P CC 00100F93 addi  x31, x0, 1 after halt
R 01 12345000
R 01 12345678
R 02 00001008
R 03 FFFFFFF8
R 04 FFFFFFFC
R 05 0000000F
R 06 000000F0
R 07 00000001
R 08 00000000
R 09 00000017
R 0A 12345688
R 0B 000000FF
R 0C 00000070
R 0D 0000000F
R 0E FFFFFFF8
R 0F 000000F8
R 10 FFFFF878
R 11 00000017
R 12 0017F878
R 15 000000B0
R 17 000000BC
R 16 000000BC
R 18 0000016C
M 40 0017F878
M 44 0000FFF8
M 48 88000000
M 4C 00000000
